/* src/excPkg.sv */
package excPkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    // Data and address width
    localparam int wordW = 32;
    // Hardware interrupt lines, line 0 belongs to the timer
    localparam int hwIntW = 6;

    //////////////////////////////////////////////////////////////////////
    // Exception codes as stored in Cause.ExcCode
    //////////////////////////////////////////////////////////////////////

    // Zero doubles as "no exception" on the detector output
    typedef enum logic [4:0] {
        excInt     = 5'd0,
        excAdEL    = 5'd4,
        excAdES    = 5'd5,
        excSyscall = 5'd8,
        excRI      = 5'd10,
        excOv      = 5'd12
    } excCodeT;

    // CP0 register numbers
    typedef enum logic [4:0] {
        cp0Sr    = 5'd12,
        cp0Cause = 5'd13,
        cp0Epc   = 5'd14
    } cp0RegT;

    // Load and store access sizes
    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } memSizeT;

    // Timer word offsets from timerBase
    typedef enum logic [1:0] {
        tmrCtrl   = 2'd0,
        tmrPreset = 2'd1,
        tmrCount  = 2'd2
    } timerRegT;

endpackage

/* src/excIfs.sv */
`timescale 1ns/1ps

// Committed instruction and its ranked exception, detector to CP0
interface excIf;
    logic                       valid;
    logic [excPkg::wordW-1:0]   pc;
    logic                       inDelaySlot;
    excPkg::excCodeT            excCode;

    modport source (output valid, pc, inDelaySlot, excCode);
    modport sink   (input  valid, pc, inDelaySlot, excCode);
endinterface

// Word bus into the timer registers
interface timerBusIf;
    // Write strobe, one cycle per store
    logic                       we;
    logic [excPkg::wordW-1:0]   addr;
    logic [excPkg::wordW-1:0]   wdata;
    // Read data, combinational from addr
    logic [excPkg::wordW-1:0]   rdata;

    modport master (output we, addr, wdata, input  rdata);
    modport slave  (input  we, addr, wdata, output rdata);
endinterface

/* src/excDetect.sv */
`timescale 1ns/1ps

module excDetect #(
    parameter logic [excPkg::wordW-1:0] instBase  = 32'h0000_3000,
    parameter logic [excPkg::wordW-1:0] instTop   = 32'h0000_6ffc,
    parameter logic [excPkg::wordW-1:0] dataTop   = 32'h0000_2fff,
    parameter logic [excPkg::wordW-1:0] timerBase = 32'h0000_7f00
) (
    input  logic                        instValid,
    input  logic [excPkg::wordW-1:0]    pc,
    input  logic                        inDelaySlot,
    input  logic                        reservedInst,
    input  logic                        overflow,
    input  logic                        syscall,
    input  logic                        memRead,
    input  logic                        memWrite,
    input  excPkg::memSizeT             memSize,
    input  logic [excPkg::wordW-1:0]    memAddr,
    input  logic [excPkg::wordW-1:0]    storeData,
    excIf.source                        excOut,
    timerBusIf.master                   timerBus
);

    // Timer spans three words
    localparam logic [excPkg::wordW-1:0] timerBytes = 32'd12;

    logic [excPkg::wordW-1:0] timerOffset;
    excPkg::timerRegT         timerReg;
    logic                     inTimer;
    logic                     inData;
    logic                     fetchErr;
    logic                     misaligned;
    logic                     dataErr;
    excPkg::excCodeT          code;

    //////////////////////////////////////////////////////////////////////
    // Address checks
    //////////////////////////////////////////////////////////////////////

    // Fetch window, both bounds inclusive
    assign fetchErr = (pc[1:0] != 2'b00) || (pc < instBase) || (pc > instTop);

    // Data memory starts at 0, dataTop is its last byte
    assign inData = (memAddr <= dataTop);
    assign inTimer = (memAddr >= timerBase) && (memAddr < timerBase + timerBytes);

    // Word index inside the timer block
    assign timerOffset = memAddr - timerBase;
    assign timerReg = excPkg::timerRegT'(timerOffset[3:2]);

    // Bytes never misalign
    assign misaligned = ((memSize == excPkg::sizeHalf) && memAddr[0]) ||
                        ((memSize == excPkg::sizeWord) && (memAddr[1:0] != 2'b00));

    always_comb begin
        dataErr = 1'b0;
        if (memRead || memWrite) begin
            if (misaligned) begin
                dataErr = 1'b1;
            end else if (!inData && !inTimer) begin
                dataErr = 1'b1;
            end else if (inTimer && (memSize != excPkg::sizeWord)) begin
                dataErr = 1'b1;
            end else if (inTimer && memWrite && (timerReg == excPkg::tmrCount)) begin
                // Count is read-only
                dataErr = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Priority encoding, fetch fault ranks highest
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        code = excPkg::excInt;
        if (instValid) begin
            if (fetchErr) begin
                code = excPkg::excAdEL;
            end else if (reservedInst) begin
                code = excPkg::excRI;
            end else if (overflow) begin
                code = excPkg::excOv;
            end else if (syscall) begin
                code = excPkg::excSyscall;
            end else if (dataErr) begin
                // A store fault wins if both strobes are up
                code = memWrite ? excPkg::excAdES : excPkg::excAdEL;
            end
        end
    end

    assign excOut.valid       = instValid;
    assign excOut.pc          = pc;
    assign excOut.inDelaySlot = inDelaySlot;
    assign excOut.excCode     = code;

    // No exception implies an aligned word to Ctrl or Preset
    assign timerBus.we    = instValid && memWrite && inTimer && (code == excPkg::excInt);
    assign timerBus.addr  = memAddr;
    assign timerBus.wdata = storeData;

endmodule

/* src/cp0Regs.sv */
`timescale 1ns/1ps

module cp0Regs (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        cp0Write,
    input  excPkg::cp0RegT              cp0Addr,
    input  logic [excPkg::wordW-1:0]    cp0WriteData,
    input  logic                        eret,
    input  logic [excPkg::hwIntW-1:0]   hwInt,
    excIf.sink                          exc,
    output logic                        excReq,
    output logic [excPkg::wordW-1:0]    epc,
    output logic [excPkg::wordW-1:0]    cp0ReadData
);

    logic [excPkg::wordW-1:0] sr;
    logic [excPkg::wordW-1:0] cause;
    logic [excPkg::wordW-1:0] epcReg;

    // SR fields
    logic [excPkg::hwIntW-1:0] intMask;
    logic                      exl;
    logic                      intEn;
    // Cause.IP, sampled lines
    logic [excPkg::hwIntW-1:0] intPend;

    logic                      intReq;
    logic                      faultReq;
    excPkg::excCodeT           recCode;

    assign intMask = sr[15:10];
    assign exl     = sr[1];
    assign intEn   = sr[0];
    assign intPend = cause[15:10];

    //////////////////////////////////////////////////////////////////////
    // Request logic
    //////////////////////////////////////////////////////////////////////

    // Interrupts come from the registered IP bits, one cycle behind the lines
    assign intReq   = intEn && (|(intPend & intMask));
    assign faultReq = (exc.excCode != excPkg::excInt);

    // Only a committed instruction can be interrupted
    // Nothing is taken while EXL is set
    assign excReq = exc.valid && !exl && (intReq || faultReq);

    // Interrupt outranks any instruction fault
    assign recCode = intReq ? excPkg::excInt : exc.excCode;

    //////////////////////////////////////////////////////////////////////
    // Register updates
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            sr     <= '0;
            cause  <= '0;
            epcReg <= '0;
        end else begin
            // IP follows the lines every cycle
            cause[15:10] <= hwInt;
            if (eret) begin
                sr[1] <= 1'b0;
            end
            if (excReq) begin
                // Branch address when the faulting op sits in a delay slot
                epcReg    <= exc.inDelaySlot ? exc.pc - 32'd4 : exc.pc;
                cause[31] <= exc.inDelaySlot;
                cause[6:2] <= recCode;
                sr[1]     <= 1'b1;
            end else if (cp0Write) begin
                case (cp0Addr)
                    excPkg::cp0Sr: sr <= cp0WriteData;
                    excPkg::cp0Epc: epcReg <= cp0WriteData;
                    // Cause is read-only
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////////

    // Same-cycle writes to SR or EPC are forwarded
    always_comb begin
        case (cp0Addr)
            excPkg::cp0Sr: cp0ReadData = cp0Write ? cp0WriteData : sr;
            excPkg::cp0Cause: cp0ReadData = cause;
            excPkg::cp0Epc: cp0ReadData = cp0Write ? cp0WriteData : epcReg;
            default: cp0ReadData = '0;
        endcase
    end

    // Return address is always word aligned
    assign epc = {epcReg[excPkg::wordW-1:2], 2'b00};

endmodule

/* src/intTimer.sv */
`timescale 1ns/1ps

module intTimer #(
    parameter logic [excPkg::wordW-1:0] timerBase = 32'h0000_7f00
) (
    input  logic        clk,
    input  logic        reset,
    timerBusIf.slave    bus,
    output logic        irq
);

    logic [excPkg::wordW-1:0] offsetBytes;
    excPkg::timerRegT         regSel;

    // Ctrl bit 0 enable, bit 3 interrupt mask
    logic [3:0]               ctrl;
    logic [excPkg::wordW-1:0] preset;
    logic [excPkg::wordW-1:0] count;
    logic                     pending;

    // Word offset from the base address
    assign offsetBytes = bus.addr - timerBase;
    assign regSel = excPkg::timerRegT'(offsetBytes[3:2]);

    //////////////////////////////////////////////////////////////////////
    // Registers and countdown
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl    <= '0;
            preset  <= '0;
            count   <= '0;
            pending <= 1'b0;
        end else if (bus.we && (regSel == excPkg::tmrCtrl)) begin
            ctrl    <= bus.wdata[3:0];
            pending <= 1'b0;
        end else if (bus.we && (regSel == excPkg::tmrPreset)) begin
            // Preset also reloads the counter
            preset  <= bus.wdata;
            count   <= bus.wdata;
            pending <= 1'b0;
        end else if (ctrl[0] && (count != '0)) begin
            count <= count - 1'b1;
            // Reaching zero raises pending, counter then stays at zero
            if (count == 32'd1) begin
                pending <= 1'b1;
            end
        end
    end

    assign irq = pending && ctrl[3];

    //////////////////////////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (regSel)
            excPkg::tmrCtrl: bus.rdata = {28'd0, ctrl};
            excPkg::tmrPreset: bus.rdata = preset;
            excPkg::tmrCount: bus.rdata = count;
            default: bus.rdata = '0;
        endcase
    end

endmodule

/* src/excUnit.sv */
`timescale 1ns/1ps

module excUnit #(
    // Fetch window, inclusive
    parameter logic [31:0] instBase  = 32'h0000_3000,
    parameter logic [31:0] instTop   = 32'h0000_6ffc,
    // Last byte of data memory
    parameter logic [31:0] dataTop   = 32'h0000_2fff,
    // Three timer words from here
    parameter logic [31:0] timerBase = 32'h0000_7f00
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        instValid,
    input  logic [31:0] pc,
    input  logic        inDelaySlot,
    input  logic        reservedInst,
    input  logic        overflow,
    input  logic        syscall,
    input  logic        memRead,
    input  logic        memWrite,
    input  logic [1:0]  memSize,
    input  logic [31:0] memAddr,
    input  logic [31:0] storeData,
    input  logic        cp0Write,
    input  logic [4:0]  cp0Addr,
    input  logic [31:0] cp0WriteData,
    input  logic        eret,
    input  logic [4:0]  extInt,
    output logic        excReq,
    output logic [31:0] epc,
    output logic [31:0] cp0ReadData,
    output logic [31:0] timerReadData
);

    excIf      excLink ();
    timerBusIf timerLink ();

    logic                      timerIrq;
    logic [excPkg::hwIntW-1:0] hwInt;

    // Timer owns line 0
    assign hwInt = {extInt, timerIrq};
    assign timerReadData = timerLink.rdata;

    //////////////////////////////////////////////////////////////////////
    // Memory-stage fault detection
    //////////////////////////////////////////////////////////////////////

    excDetect #(
        .instBase  (instBase),
        .instTop   (instTop),
        .dataTop   (dataTop),
        .timerBase (timerBase)
    ) detect0 (
        .instValid    (instValid),
        .pc           (pc),
        .inDelaySlot  (inDelaySlot),
        .reservedInst (reservedInst),
        .overflow     (overflow),
        .syscall      (syscall),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .memSize      (excPkg::memSizeT'(memSize)),
        .memAddr      (memAddr),
        .storeData    (storeData),
        .excOut       (excLink.source),
        .timerBus     (timerLink.master)
    );

    cp0Regs cp0 (
        .clk          (clk),
        .reset        (reset),
        .cp0Write     (cp0Write),
        .cp0Addr      (excPkg::cp0RegT'(cp0Addr)),
        .cp0WriteData (cp0WriteData),
        .eret         (eret),
        .hwInt        (hwInt),
        .exc          (excLink.sink),
        .excReq       (excReq),
        .epc          (epc),
        .cp0ReadData  (cp0ReadData)
    );

    intTimer #(
        .timerBase (timerBase)
    ) timer0 (
        .clk   (clk),
        .reset (reset),
        .bus   (timerLink.slave),
        .irq   (timerIrq)
    );

endmodule

/* testbench/excUnit_asserts.sv */
`timescale 1ns/1ps

// Request and EXL handshake checks inside cp0Regs
module excUnitAsserts (
    input logic        clk,
    input logic        reset,
    input logic        excReq,
    input logic        exl,
    input logic        eret,
    input logic        cp0Write,
    input logic [4:0]  cp0Addr,
    input logic [31:0] cp0WriteData,
    input logic [31:0] epc
);

    logic srWrite;
    logic epcWrite;

    assign srWrite  = cp0Write && (cp0Addr == excPkg::cp0Sr);
    assign epcWrite = cp0Write && (cp0Addr == excPkg::cp0Epc);

    // EXL holds until eret or an SR write
    // No new request while an exception is in service
    noReqUnderExl: assert property (@(posedge clk) disable iff (reset)
        exl && !eret && !srWrite |=> !excReq)
        else $error("excReq raised while EXL is set");

    // Taking an exception sets EXL at the next edge
    exlAfterReq: assert property (@(posedge clk) disable iff (reset) excReq |=> exl)
        else $error("EXL not set in the cycle after excReq");

    // Unaligned EPC write data comes back word aligned
    epcAligned: assert property (@(posedge clk) disable iff (reset)
        epcWrite && !excReq |=> epc == {$past(cp0WriteData[31:2]), 2'b00})
        else $error("epc low bits not zero after an EPC write");

endmodule

// Attach to every cp0Regs instance
bind cp0Regs excUnitAsserts asserts0 (
    .clk          (clk),
    .reset        (reset),
    .excReq       (excReq),
    .exl          (exl),
    .eret         (eret),
    .cp0Write     (cp0Write),
    .cp0Addr      (cp0Addr),
    .cp0WriteData (cp0WriteData),
    .epc          (epc)
);

/* testbench/excUnitTb.sv */
`timescale 1ns/1ps

module excUnitTb;

    localparam int halfPeriod = 4;
    localparam int maxLines   = 128;
    localparam int numInputs  = 16;
    localparam int numOutputs = 4;

    // DUT inputs
    logic        clk;
    logic        reset;
    logic        instValid;
    logic [31:0] pc;
    logic        inDelaySlot;
    logic        reservedInst;
    logic        overflow;
    logic        syscall;
    logic        memRead;
    logic        memWrite;
    logic [1:0]  memSize;
    logic [31:0] memAddr;
    logic [31:0] storeData;
    logic        cp0Write;
    logic [4:0]  cp0Addr;
    logic [31:0] cp0WriteData;
    logic        eret;
    logic [4:0]  extInt;
    // DUT outputs
    logic        excReq;
    logic [31:0] epc;
    logic [31:0] cp0ReadData;
    logic [31:0] timerReadData;

    // Stimulus table, one row per cycle
    int          testOf [maxLines];
    logic [31:0] stim [maxLines][numInputs];
    logic [31:0] expVal [maxLines][numOutputs];
    logic        expCare [maxLines][numOutputs];
    int          numLines;
    logic        loadOk;

    // Run bookkeeping
    int errors;
    int testErrors;
    int testsRun;
    int testsFailed;
    int checks;
    int curTest;
    int row;
    int cycleCount;
    int cycleLimit = 0;

    excUnit #(
        .instBase  (32'h0000_3000),
        .instTop   (32'h0000_6ffc),
        .dataTop   (32'h0000_2fff),
        .timerBase (32'h0000_7f00)
    ) dut0 (
        .clk           (clk),
        .reset         (reset),
        .instValid     (instValid),
        .pc            (pc),
        .inDelaySlot   (inDelaySlot),
        .reservedInst  (reservedInst),
        .overflow      (overflow),
        .syscall       (syscall),
        .memRead       (memRead),
        .memWrite      (memWrite),
        .memSize       (memSize),
        .memAddr       (memAddr),
        .storeData     (storeData),
        .cp0Write      (cp0Write),
        .cp0Addr       (cp0Addr),
        .cp0WriteData  (cp0WriteData),
        .eret          (eret),
        .extInt        (extInt),
        .excReq        (excReq),
        .epc           (epc),
        .cp0ReadData   (cp0ReadData),
        .timerReadData (timerReadData)
    );

    //////////////////////////////////////////////////////////////////////
    // Clock and cycle limit
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // Limit known once the table is loaded
    initial begin
        cycleCount = 0;
        wait (cycleLimit > 0);
        while (cycleCount <= cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Run stopped after %0d cycles without finishing the table", cycleCount);
        $display("TESTS FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Table loading
    //////////////////////////////////////////////////////////////////////

    // Dash means the output is not checked on that row
    task automatic storeExpect(input int r, input int col, input string tok);
        if (tok == "-") begin
            expCare[r][col] = 1'b0;
            expVal[r][col]  = '0;
        end else begin
            expCare[r][col] = 1'b1;
            expVal[r][col]  = tok.atohex();
        end
    endtask

    task automatic loadTests();
        int          fd;
        int          n;
        int          k;
        int          tnum;
        string       line;
        string       tokExc;
        string       tokEpc;
        string       tokRead;
        string       tokTimer;
        logic [31:0] f [numInputs];
        loadOk   = 1'b0;
        numLines = 0;
        fd = $fopen("testbench/excUnit_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testbench/excUnit_tests.txt");
        end else begin
            loadOk = 1'b1;
            while ($fgets(line, fd) != 0) begin
                // Skip blanks and column notes
                if (line.len() > 2 && line.getc(0) != "#") begin
                    n = $sscanf(line,
                        "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %s %s %s %s",
                        tnum, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14], f[15],
                        tokExc, tokEpc, tokRead, tokTimer);
                    if (n != 21 || numLines >= maxLines) begin
                        $display("Bad or surplus line in the tests file: %s", line);
                        loadOk = 1'b0;
                    end else begin
                        testOf[numLines] = tnum;
                        for (k = 0; k < numInputs; k++) begin
                            stim[numLines][k] = f[k];
                        end
                        storeExpect(numLines, 0, tokExc);
                        storeExpect(numLines, 1, tokEpc);
                        storeExpect(numLines, 2, tokRead);
                        storeExpect(numLines, 3, tokTimer);
                        numLines++;
                    end
                end
            end
            $fclose(fd);
            if (numLines == 0) begin
                $display("The tests file holds no stimulus");
                loadOk = 1'b0;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Drive, compare, report
    //////////////////////////////////////////////////////////////////////

    // Column order matches the file header
    task automatic applyStimulus(input int r);
        instValid    = stim[r][0][0];
        pc           = stim[r][1];
        inDelaySlot  = stim[r][2][0];
        reservedInst = stim[r][3][0];
        overflow     = stim[r][4][0];
        syscall      = stim[r][5][0];
        memRead      = stim[r][6][0];
        memWrite     = stim[r][7][0];
        memSize      = stim[r][8][1:0];
        memAddr      = stim[r][9];
        storeData    = stim[r][10];
        cp0Write     = stim[r][11][0];
        cp0Addr      = stim[r][12][4:0];
        cp0WriteData = stim[r][13];
        eret         = stim[r][14][0];
        extInt       = stim[r][15][4:0];
    endtask

    task automatic compareOutput(input string name, input int r, input int col,
                                 input logic [31:0] actual);
        if (expCare[r][col]) begin
            checks++;
            if (actual !== expVal[r][col]) begin
                $display("FAILED at %0t: %s expected %h, got %h (test %0d)",
                         $time, name, expVal[r][col], actual, testOf[r]);
                errors++;
                testErrors++;
            end
        end
    endtask

    task automatic reportTest();
        testsRun++;
        if (testErrors == 0) begin
            $display("Test %0d passed", curTest);
        end else begin
            $display("Test %0d failed with %0d errors", curTest, testErrors);
            testsFailed++;
        end
        testErrors = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset        = 1'b1;
        instValid    = 1'b0;
        pc           = '0;
        inDelaySlot  = 1'b0;
        reservedInst = 1'b0;
        overflow     = 1'b0;
        syscall      = 1'b0;
        memRead      = 1'b0;
        memWrite     = 1'b0;
        memSize      = '0;
        memAddr      = '0;
        storeData    = '0;
        cp0Write     = 1'b0;
        cp0Addr      = '0;
        cp0WriteData = '0;
        eret         = 1'b0;
        extInt       = '0;
        errors       = 0;
        testErrors   = 0;
        testsRun     = 0;
        testsFailed  = 0;
        checks       = 0;
        curTest      = -1;
        loadTests();
        cycleLimit = 2 * numLines + 20;
        // Two reset cycles, release on a falling edge
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        if (loadOk) begin
            for (row = 0; row < numLines; row++) begin
                if (testOf[row] != curTest) begin
                    if (curTest >= 0) begin
                        reportTest();
                    end
                    curTest = testOf[row];
                end
                applyStimulus(row);
                // Sample one ns ahead of the rising edge
                #(halfPeriod - 1);
                compareOutput("excReq", row, 0, {31'd0, excReq});
                compareOutput("epc", row, 1, epc);
                compareOutput("cp0ReadData", row, 2, cp0ReadData);
                compareOutput("timerReadData", row, 3, timerReadData);
                @(negedge clk);
            end
            reportTest();
        end
        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checks, errors);
        if (loadOk && errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* excUnit.f */
src/excPkg.sv
src/excIfs.sv
src/excDetect.sv
src/cp0Regs.sv
src/intTimer.sv
src/excUnit.sv
testbench/excUnit_asserts.sv
testbench/excUnitTb.sv

/* build.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert --top-module excUnitTb -f excUnit.f -o excUnitSim \
    && ./obj_dir/excUnitSim | tee /dev/stderr | grep -q "TESTS PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* testbench/excUnit_tests.txt */
# test valid pc ds ri ov sc memRead memWrite size addr storeData cp0Write cp0Addr cp0Data eret ext
# then expected excReq epc cp0ReadData timerReadData, all hex, '-' marks a don't care
1 1 3000 0 1 1 0 1 0 2 2 0 0 d 0 0 0 1 0 0 -
1 0 0 0 0 0 0 0 0 0 0 0 0 d 0 0 0 0 3000 28 -
1 0 0 0 0 0 0 0 0 0 0 0 0 e 0 1 0 0 3000 3000 -
1 1 3004 0 0 1 1 0 0 0 0 0 0 d 0 0 0 1 3000 28 -
1 0 0 0 0 0 0 0 0 0 0 0 0 d 0 1 0 0 3004 30 -
1 1 7000 0 1 0 0 0 0 0 0 0 0 c 0 0 0 1 3004 0 -
1 0 0 0 0 0 0 0 0 0 0 0 0 d 0 1 0 0 7000 10 -
2 1 3100 1 0 0 1 0 0 0 0 0 0 c 0 0 0 1 7000 0 -
2 1 3200 0 0 1 0 0 0 0 0 0 0 d 0 0 0 0 30fc 80000020 -
2 0 0 0 0 0 0 0 0 0 0 0 0 c 0 1 0 0 30fc 2 -
2 1 3200 0 0 1 0 0 0 0 0 0 0 c 0 0 0 1 30fc 0 -
2 0 0 0 0 0 0 0 0 0 0 0 0 d 0 1 0 0 3200 30 -
3 1 3000 0 0 0 0 0 1 2 7f08 5 0 c 0 0 0 1 3200 0 0
3 0 0 0 0 0 0 0 0 0 7f00 0 0 d 0 1 0 0 3000 14 0
3 1 3004 0 0 0 0 0 1 1 7f00 9 0 c 0 0 0 1 3000 0 0
3 0 0 0 0 0 0 0 0 0 7f00 0 0 d 0 1 0 0 3004 14 0
3 1 3008 0 0 0 0 1 0 2 4000 0 0 c 0 0 0 1 3004 0 -
3 0 0 0 0 0 0 0 0 0 0 0 0 d 0 1 0 0 3008 10 -
3 1 300c 0 0 0 0 1 0 2 100 0 0 c 0 0 0 0 3008 0 -
4 0 0 0 0 0 0 0 0 0 0 0 1 c 401 0 0 0 3008 401 -
4 1 3014 0 0 0 0 0 1 2 7f04 3 0 c 0 0 0 0 3008 401 0
4 1 3018 0 0 0 0 0 1 2 7f00 9 0 c 0 0 0 0 3008 401 0
4 0 0 0 0 0 0 0 0 0 7f08 0 0 d 0 0 0 0 3008 10 3
4 0 0 0 0 0 0 0 0 0 7f08 0 0 d 0 0 0 0 3008 10 2
4 0 0 0 0 0 0 0 0 0 7f08 0 0 d 0 0 0 0 3008 10 1
4 1 301c 0 0 0 0 0 0 0 7f08 0 0 d 0 0 0 0 3008 10 0
4 1 3020 0 0 0 0 0 0 0 7f08 0 0 d 0 0 0 1 3008 410 0
4 1 3024 0 0 0 0 0 1 2 7f00 8 0 d 0 1 0 0 3020 400 9
4 0 0 0 0 0 0 0 0 0 7f00 0 0 d 0 0 0 0 3020 400 8
4 1 3028 0 0 0 0 0 0 0 7f00 0 0 d 0 0 0 0 3020 0 8
5 0 0 0 0 0 0 0 0 0 0 0 1 e 567b 0 0 0 3020 567b -
5 0 0 0 0 0 0 0 0 0 0 0 0 e 0 0 0 0 5678 567b -
5 0 0 0 0 0 0 0 0 0 0 0 1 d ffffffff 0 0 0 5678 0 -
5 0 0 0 0 0 0 0 0 0 0 0 0 d 0 0 0 0 5678 0 -
5 0 0 0 0 0 0 0 0 0 0 0 1 c 1 0 1f 0 5678 1 -
5 1 302c 0 0 0 0 0 0 0 0 0 0 d 0 0 1f 0 5678 f800 -
5 0 0 0 0 0 0 0 0 0 0 0 0 c 0 0 1f 0 5678 1 -
